// File: compile.f
design/jt900h_isa_pkg.sv
design/jt900h_ctrl_pkg.sv
design/jt900h_ctrl_fetch.sv
design/jt900h_ctrl_exec.sv
design/jt900h_ctrl_seq.sv
design/jt900h_ctrl.sv
verification/jt900h_ctrl_tb.sv

// File: design/jt900h_ctrl.sv
// TLCS-900H instruction sequencing control unit, top level
`timescale 1ns/1ps
`default_nettype none

module jt900h_ctrl (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               cen,
    input  logic [31:0]                        op,      // byte 0 in bits 7:0
    input  logic                               op_ok,
    output logic [jt900h_isa_pkg::fetch_w-1:0] fetched,
    output logic                               pc_we,
    output logic                               rfp_we,
    output logic                               inc_rfp,
    output logic                               dec_rfp,
    output logic                               flag_we,
    output jt900h_ctrl_pkg::alu_ctrl_t         alu,
    output jt900h_ctrl_pkg::regs_ctrl_t        regs
);

    import jt900h_isa_pkg::*;
    import jt900h_ctrl_pkg::*;

    dec_t fetch_dec;
    dec_t exec_dec;
    zz_t  op_zz;

    jt900h_ctrl_fetch u_fetch (
        .op   (op),
        .regs (regs),
        .alu  (alu),
        .dec  (fetch_dec)
    );

    jt900h_ctrl_exec u_exec (
        .op    (op),
        .op_zz (op_zz),
        .regs  (regs),
        .alu   (alu),
        .dec   (exec_dec)
    );

    jt900h_ctrl_seq u_seq (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .op        (op),
        .op_ok     (op_ok),
        .fetch_dec (fetch_dec),
        .exec_dec  (exec_dec),
        .fetched   (fetched),
        .op_zz     (op_zz),
        .pc_we     (pc_we),
        .rfp_we    (rfp_we),
        .inc_rfp   (inc_rfp),
        .dec_rfp   (dec_rfp),
        .flag_we   (flag_we),
        .alu       (alu),
        .regs      (regs)
    );

endmodule

`default_nettype wire

// File: design/jt900h_ctrl_exec.sv
// execute-phase decoder of the second half of register-prefixed instructions
`timescale 1ns/1ps
`default_nettype none

module jt900h_ctrl_exec (
    input  logic [31:0]                 op,
    input  jt900h_isa_pkg::zz_t         op_zz,
    input  jt900h_ctrl_pkg::regs_ctrl_t regs,
    input  jt900h_ctrl_pkg::alu_ctrl_t  alu,
    output jt900h_ctrl_pkg::dec_t       dec
);

    import jt900h_isa_pkg::*;
    import jt900h_ctrl_pkg::*;

    logic imm_form;                                         // operand in the next bytes
    logic alu_form;                                         // ALU r,# needs the dummy slot

    always_comb begin
        dec         = '0;
        dec.phase   = ph_fetch;
        dec.zz      = op_zz;
        dec.alu     = alu;
        dec.regs    = regs;
        dec.regs.we = '0;
        imm_form    = 1'b0;
        alu_form    = 1'b0;
        casez (op[7:0])
            8'b1000_1???: begin                             // LD R,r
                dec.regs.src = regs.dst;
                dec.regs.dst = expand_reg(op[2:0], op_zz);
                dec.alu.op   = alu_move;
                dec.regs.we  = expand_zz(op_zz);
                dec.fetched  = 2'd1;
            end
            8'b1001_1???: begin                             // LD r,R
                dec.regs.src = expand_reg(op[2:0], op_zz);
                dec.alu.op   = alu_move;
                dec.regs.we  = expand_zz(op_zz);
                dec.fetched  = 2'd1;
            end
            8'b1010_1???: begin                             // LD r,#3
                dec.alu.imm  = {29'd0, op[2:0]};
                dec.alu.op   = alu_move;
                dec.alu.smux = 1'b1;
                dec.regs.we  = expand_zz(op_zz);
                dec.fetched  = 2'd1;
            end
            8'b0011_0011: begin                             // BIT #4,r
                dec.alu.imm  = {28'd0, op[11:8]};
                dec.alu.op   = alu_bit;
                dec.alu.smux = 1'b1;
                dec.flag_we  = 1'b1;
                dec.fetched  = 2'd2;
            end
            8'b0000_111?: begin                             // BS1F, BS1B
                dec.alu.op   = op[0] ? alu_bs1b : alu_bs1f;
                dec.regs.dst = r_index_a;
                dec.regs.we  = expand_zz(op_zz);
                dec.fetched  = 2'd1;
            end
            8'h03: begin dec.alu.op = alu_move;  imm_form = 1'b1; end   // LD r,#
            8'h3c: begin dec.alu.op = alu_mdec1; imm_form = 1'b1; end
            8'h3d: begin dec.alu.op = alu_mdec2; imm_form = 1'b1; end
            8'h3e: begin dec.alu.op = alu_mdec4; imm_form = 1'b1; end
            8'b1000_0???, 8'b1001_0???, 8'b1010_0???, 8'b1100_0???, 8'b1110_0???: begin
                // ALU R,r with source and destination swapped
                dec.regs.src = regs.dst;
                dec.regs.dst = expand_reg(op[2:0], op_zz);
                dec.alu.op   = op[7:4] == 4'b1000 ? alu_add :
                               op[7:4] == 4'b1001 ? alu_adc :
                               op[7:4] == 4'b1010 ? alu_sub :
                               op[7:4] == 4'b1100 ? alu_and : alu_or;
                dec.keep_we  = expand_zz(op_zz);
                dec.phase    = ph_dummy;
            end
            8'b1100_10??, 8'b1100_1100, 8'b1100_1110: begin  // ALU r,#
                dec.alu.op = op[2:0] == 3'd0 ? alu_add :
                             op[2:0] == 3'd1 ? alu_adc :
                             op[2:0] == 3'd2 ? alu_sub :
                             op[2:0] == 3'd3 ? alu_sbc :
                             op[2:0] == 3'd4 ? alu_and : alu_or;
                imm_form   = 1'b1;
                alu_form   = 1'b1;
            end
            default: ;
        endcase
        if (imm_form) begin
            dec.alu.smux = 1'b1;
            dec.fetched  = 2'd2;
            if (op_zz == zz_byte) begin
                dec.alu.imm = {24'd0, op[15:8]};
                dec.regs.we = expand_zz(op_zz);
                dec.nodummy = alu_form;
                dec.phase   = alu_form ? ph_dummy : ph_fetch;
            end else begin
                dec.alu.imm[7:0] = op[15:8];                // upper bytes come in fill
                dec.alu.wait_imm = 1'b1;
                dec.keep_we      = expand_zz(op_zz);
                dec.phase        = ph_fill_imm;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/jt900h_ctrl_fetch.sv
// fetch-phase decoder of the first opcode byte
`timescale 1ns/1ps
`default_nettype none

module jt900h_ctrl_fetch (
    input  logic [31:0]                 op,
    input  jt900h_ctrl_pkg::regs_ctrl_t regs,
    input  jt900h_ctrl_pkg::alu_ctrl_t  alu,
    output jt900h_ctrl_pkg::dec_t       dec
);

    import jt900h_isa_pkg::*;
    import jt900h_ctrl_pkg::*;

    opbyte_u b;
    zz_t     ld_zz;

    assign b     = op[7:0];
    assign ld_zz = b.ldi.sz == 3'd2 ? zz_byte : b.ldi.sz == 3'd3 ? zz_word : zz_long;

    always_comb begin
        dec              = '0;
        dec.phase        = ph_fetch;
        dec.alu.op       = alu_nop;
        dec.alu.imm      = alu.imm;
        dec.regs         = regs;
        dec.regs.we      = '0;
        if (b.pfx.cls == 2'b11 && (b.pfx.mode || b.pfx.rg == 3'd7)) begin
            dec.zz    = b.pfx.zz;
            dec.phase = ph_exec;
            if (b.pfx.mode) begin                           // register in the prefix
                dec.regs.dst = expand_reg(b.pfx.rg, b.pfx.zz);
                dec.fetched  = 2'd1;
            end else begin                                  // full register code in byte 1
                dec.regs.dst = op[15:8];
                dec.fetched  = 2'd2;
            end
            dec.regs.src = dec.regs.dst;
        end else if (!b.ldi.zero_hi && !b.ldi.zero_lo && b.ldi.sz inside {3'd2, 3'd3, 3'd4}) begin
            // LD R,#
            dec.zz       = ld_zz;
            dec.regs.dst = expand_reg(b.ldi.rg, ld_zz);
            dec.alu.imm  = {24'd0, op[15:8]};
            dec.alu.op   = alu_move;
            dec.alu.smux = 1'b1;
            dec.fetched  = 2'd2;
            if (ld_zz == zz_byte) begin
                dec.regs.we = expand_zz(ld_zz);
            end else begin
                dec.phase        = ph_fill_imm;
                dec.alu.wait_imm = 1'b1;
                dec.keep_we      = expand_zz(ld_zz);
            end
        end else begin
            case (op[7:0])
                8'h00: dec.fetched = 2'd1;                  // NOP
                8'h12: begin                                // CCF
                    dec.flag_we = 1'b1;
                    dec.alu.op  = alu_ccf;
                    dec.fetched = 2'd1;
                end
                8'h17: begin                                // LDF #n
                    dec.rfp_we  = 1'b1;
                    dec.alu.imm = {24'd0, op[15:8]};
                    dec.fetched = 2'd2;
                end
                8'h1a, 8'h1b: begin                         // JP #16 / JP #24
                    dec.zz           = op[0] ? zz_jp24 : zz_word;
                    dec.alu.imm      = {24'd0, op[15:8]};
                    dec.alu.wait_imm = 1'b1;
                    dec.keep_pc_we   = 1'b1;
                    dec.phase        = ph_fill_imm;
                    dec.fetched      = 2'd2;
                end
                8'h0c: begin                                // INCF
                    dec.inc_rfp = 1'b1;
                    dec.fetched = 2'd1;
                end
                8'h0d: begin                                // DECF
                    dec.dec_rfp = 1'b1;
                    dec.fetched = 2'd1;
                end
                default: ;                                  // wait for a known byte
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/jt900h_ctrl_pkg.sv
// control unit definitions: phase encoding and the control words passed between blocks
`default_nettype none

package jt900h_ctrl_pkg;

    import jt900h_isa_pkg::*;

    typedef enum logic [2:0] {
        ph_fetch,
        ph_exec,
        ph_fill_imm,
        ph_dummy,
        ph_illegal
    } phase_t;

    typedef struct packed {
        alu_op_t     op;
        logic [31:0] imm;
        logic        smux;                   // ALU source from imm
        logic        wait_imm;               // immediate still being assembled
    } alu_ctrl_t;

    typedef struct packed {
        we_t       we;
        reg_code_t dst;
        reg_code_t src;
    } regs_ctrl_t;

    // next-state proposal from one decoder
    typedef struct packed {
        phase_t             phase;
        logic [fetch_w-1:0] fetched;
        alu_ctrl_t          alu;
        regs_ctrl_t         regs;
        zz_t                zz;
        we_t                keep_we;         // write strobe held for a later phase
        logic               flag_we;
        logic               rfp_we;
        logic               inc_rfp;
        logic               dec_rfp;
        logic               keep_pc_we;
        logic               nodummy;         // dummy phase consumes no byte
    } dec_t;

endpackage

`default_nettype wire

// File: design/jt900h_ctrl_seq.sv
// phase sequencer: proposal select, immediate fill, memory wait and output registers
`timescale 1ns/1ps
`default_nettype none

module jt900h_ctrl_seq (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       cen,
    input  logic [31:0]                                op,
    input  logic                                       op_ok,
    input  jt900h_ctrl_pkg::dec_t                      fetch_dec,
    input  jt900h_ctrl_pkg::dec_t                      exec_dec,
    output logic [jt900h_isa_pkg::fetch_w-1:0]         fetched,
    output jt900h_isa_pkg::zz_t                        op_zz,
    output logic                                       pc_we,
    output logic                                       rfp_we,
    output logic                                       inc_rfp,
    output logic                                       dec_rfp,
    output logic                                       flag_we,
    output jt900h_ctrl_pkg::alu_ctrl_t                 alu,
    output jt900h_ctrl_pkg::regs_ctrl_t                regs
);

    import jt900h_isa_pkg::*;
    import jt900h_ctrl_pkg::*;

    phase_t phase;
    dec_t   nx;
    logic   nx_pc_we;
    we_t    keep_we;
    logic   keep_pc_we;
    logic   nodummy;
    logic   mem_wait;                                       // bytes consumed last cycle

    always_comb begin
        nx            = '0;
        nx.phase      = phase;
        nx.alu        = alu;
        nx.regs       = regs;
        nx.regs.we    = '0;
        nx.zz         = op_zz;
        nx.keep_we    = keep_we;
        nx.keep_pc_we = keep_pc_we;
        nx.nodummy    = nodummy;
        nx_pc_we      = 1'b0;
        if (op_ok && !mem_wait) begin
            case (phase)
                ph_fetch: nx = fetch_dec;
                ph_exec:  nx = exec_dec;
                ph_fill_imm: begin
                    nx.phase        = ph_fetch;
                    nx.alu.wait_imm = 1'b0;
                    nx.regs.we      = keep_we;
                    nx_pc_we        = keep_pc_we;
                    nx.keep_we      = '0;
                    nx.keep_pc_we   = 1'b0;
                    case (op_zz)
                        zz_word: begin
                            nx.alu.imm[31:8] = {16'd0, op[7:0]};
                            nx.fetched       = 2'd1;
                        end
                        zz_long: begin
                            nx.alu.imm[31:8] = op[23:0];
                            nx.fetched       = 2'd3;
                        end
                        zz_jp24: begin                      // top byte already clear
                            nx.alu.imm[23:8] = op[15:0];
                            nx.fetched       = 2'd2;
                        end
                        default: ;
                    endcase
                end
                ph_dummy: begin
                    nx.phase   = ph_fetch;
                    nx.regs.we = keep_we;                   // ALU result lands now
                    nx.keep_we = '0;
                    nx.nodummy = 1'b0;
                    nx.fetched = nodummy ? 2'd0 : 2'd1;
                end
                default: nx.phase = ph_illegal;
            endcase
        end
    end

    assign fetched = nx.fetched;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase      <= ph_fetch;
            op_zz      <= zz_byte;
            keep_we    <= '0;
            keep_pc_we <= 1'b0;
            nodummy    <= 1'b0;
            mem_wait   <= 1'b0;
            alu        <= '{op: alu_nop, default: '0};
            regs       <= '0;
            pc_we      <= 1'b0;
            rfp_we     <= 1'b0;
            inc_rfp    <= 1'b0;
            dec_rfp    <= 1'b0;
            flag_we    <= 1'b0;
        end else if (cen) begin
            phase      <= nx.phase;
            op_zz      <= nx.zz;
            keep_we    <= nx.keep_we;
            keep_pc_we <= nx.keep_pc_we;
            nodummy    <= nx.nodummy;
            mem_wait   <= nx.fetched != '0;
            alu        <= nx.alu;
            regs       <= nx.regs;
            pc_we      <= nx_pc_we;
            rfp_we     <= nx.rfp_we;
            inc_rfp    <= nx.inc_rfp;
            dec_rfp    <= nx.dec_rfp;
            flag_we    <= nx.flag_we;
        end
    end

endmodule

`default_nettype wire

// File: design/jt900h_isa_pkg.sv
// instruction-set definitions for the TLCS-900H control unit: opcode views, ALU codes, sizes
`default_nettype none

package jt900h_isa_pkg;

    localparam int unsigned fetch_w = 2;     // width of the consumed byte count
    localparam logic [7:0] r_index_a = 8'he0; // BS1F/BS1B destination

    typedef logic [1:0] zz_t;
    typedef logic [7:0] reg_code_t;
    typedef logic [2:0] we_t;

    localparam zz_t zz_byte = 2'd0;
    localparam zz_t zz_word = 2'd1;
    localparam zz_t zz_long = 2'd2;
    localparam zz_t zz_jp24 = 2'd3;          // 24-bit jump target fill

    typedef enum logic [5:0] {
        alu_nop, alu_move, alu_add, alu_adc, alu_sub, alu_sbc, alu_and, alu_or,
        alu_ccf, alu_bit, alu_bs1f, alu_bs1b, alu_mdec1, alu_mdec2, alu_mdec4
    } alu_op_t;

    // 11zz_1rrr and 11zz_0111
    typedef struct packed {
        logic [1:0] cls;
        zz_t        zz;
        logic       mode;                    // set for the short register form
        logic [2:0] rg;
    } prefix_t;

    // 0sss_0rrr, LD R,#
    typedef struct packed {
        logic       zero_hi;
        logic [2:0] sz;
        logic       zero_lo;
        logic [2:0] rg;
    } ldimm_t;

    typedef union packed {
        prefix_t pfx;
        ldimm_t  ldi;
    } opbyte_u;

    function automatic we_t expand_zz(zz_t zz);
        if (zz == zz_byte)
            return 3'b001;
        else if (zz == zz_word)
            return 3'b010;
        else
            return 3'b100;
    endfunction

    // short register code to the full register file address
    function automatic reg_code_t expand_reg(logic [2:0] rg, zz_t zz);
        if (zz == zz_byte)
            return {4'he, rg[2:1], 1'b0, ~rg[0]};
        else if (rg[2])
            return {4'hf, rg[1:0], 2'b00};
        else
            return {4'he, rg[1:0], 2'b00};
    endfunction

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module jt900h_ctrl_tb -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "Finished with no errors"; then
    exit 0
else
    exit 1
fi

// File: verification/jt900h_ctrl_tb.sv
// testbench for the TLCS-900H control unit: byte-stream program model and directed tests
`timescale 1ns/1ps
`default_nettype none

module jt900h_ctrl_tb;

    import jt900h_isa_pkg::*;
    import jt900h_ctrl_pkg::*;

    localparam int prog_bytes = 52;                         // bytes over all tests
    localparam int cycle_limit = prog_bytes * 4 + 64 + 50;  // stalls plus margin

    logic        clk;
    logic        rst;
    logic        cen;
    logic [31:0] op;
    logic        op_ok;
    logic [1:0]  fetched;
    logic        pc_we;
    logic        rfp_we;
    logic        inc_rfp;
    logic        dec_rfp;
    logic        flag_we;
    alu_ctrl_t   alu;
    regs_ctrl_t  regs;

    logic [7:0]  prog [0:255];
    logic [7:0]  ptr;
    logic [31:0] lfsr;
    int          cycles;

    jt900h_ctrl i_jt900h_ctrl (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .op      (op),
        .op_ok   (op_ok),
        .fetched (fetched),
        .pc_we   (pc_we),
        .rfp_we  (rfp_we),
        .inc_rfp (inc_rfp),
        .dec_rfp (dec_rfp),
        .flag_we (flag_we),
        .alu     (alu),
        .regs    (regs)
    );

    always #5 clk = ~clk;

    // external PC follows the consumed byte count
    always @(posedge clk or posedge rst) begin
        if (rst)
            ptr <= 8'd0;
        else if (op_ok)
            ptr <= ptr + 8'(fetched);
    end

    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;  // galois step
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check(input string test, input string what,
                         input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("** Error %s: %s expected %h, actual %h", test, what, exp, act);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    // one falling edge, new op window from the pointer
    task automatic tick();
        @(negedge clk);
        op = {prog[ptr + 8'd3], prog[ptr + 8'd2], prog[ptr + 8'd1], prog[ptr]};
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: the control unit stopped producing end strobes");
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    function automatic logic any_strobe();
        return (|regs.we) | pc_we | flag_we | rfp_we | inc_rfp | dec_rfp;
    endfunction

    task automatic wait_strobe();
        tick();
        while (!any_strobe())
            tick();
    endtask

    // register file address of a short register code
    function automatic logic [7:0] full_reg(logic [2:0] rg, logic [1:0] zz);
        if (zz == 2'd0)
            return 8'he0 + 8'(rg[2:1]) * 8'd4 + 8'(!rg[0]);
        return (rg[2] ? 8'hf0 : 8'he0) + 8'(rg[1:0]) * 8'd4;
    endfunction

    function automatic logic [31:0] size_we(logic [1:0] zz);
        return 32'(3'b001 << zz);
    endfunction

    task automatic ld_imm_test();
        logic [31:0] rg;
        logic [31:0] imm;
        logic [31:0] exp_imm;
        logic [7:0]  start;
        int          n;
        for (int s = 0; s < 3; s++) begin
            draw(3, rg);
            draw(32, imm);
            start = ptr;
            n = s == 0 ? 1 : s == 1 ? 2 : 4;
            prog[start] = {1'b0, 3'(s + 2), 1'b0, rg[2:0]};
            for (int i = 0; i < n; i++)
                prog[start + 8'(i) + 8'd1] = imm[8*i +: 8];
            exp_imm = n == 1 ? {24'd0, imm[7:0]} : n == 2 ? {16'd0, imm[15:0]} : imm;
            wait_strobe();
            check("ld_imm_test", "regs.we", size_we(2'(s)), 32'(regs.we));
            check("ld_imm_test", "regs.dst", 32'(full_reg(rg[2:0], 2'(s))), 32'(regs.dst));
            check("ld_imm_test", "alu.op", 32'(alu_move), 32'(alu.op));
            check("ld_imm_test", "alu.smux", 32'd1, 32'(alu.smux));
            check("ld_imm_test", "alu.wait_imm", 32'd0, 32'(alu.wait_imm));
            check("ld_imm_test", "alu.imm", exp_imm, alu.imm);
            check("ld_imm_test", "pointer", 32'(start + 8'(n + 1)), 32'(ptr));
        end
    endtask

    task automatic jp_test();
        logic [31:0] tgt;
        logic [7:0]  start;
        for (int k = 0; k < 2; k++) begin
            draw(24, tgt);
            if (k == 0)
                tgt[23:16] = 8'd0;
            start = ptr;
            prog[start] = k == 1 ? 8'h1b : 8'h1a;
            for (int i = 0; i < k + 2; i++)
                prog[start + 8'(i) + 8'd1] = tgt[8*i +: 8];
            wait_strobe();
            check("jp_test", "pc_we", 32'd1, 32'(pc_we));
            check("jp_test", "alu.imm", {8'd0, tgt[23:0]}, alu.imm);
            check("jp_test", "pointer", 32'(start + 8'(k + 3)), 32'(ptr));
        end
    endtask

    task automatic reg_alu_test();
        logic [3:0]  nib [4] = '{4'h8, 4'ha, 4'he, 4'hc};
        alu_op_t     exp_op [4] = '{alu_add, alu_sub, alu_or, alu_and};
        logic [31:0] r;
        logic [31:0] code;
        logic [31:0] rg;
        logic [1:0]  zz;
        logic [7:0]  start;
        for (int k = 0; k < 4; k++) begin
            draw(2, r);
            zz = r[1:0] == 2'd3 ? 2'd2 : r[1:0];
            draw(8, code);
            draw(3, rg);
            start = ptr;
            prog[start] = {2'b11, zz, 4'b0111};             // full register code follows
            prog[start + 8'd1] = code[7:0];
            prog[start + 8'd2] = {nib[k], 1'b0, rg[2:0]};
            wait_strobe();
            check("reg_alu_test", "regs.we", size_we(zz), 32'(regs.we));
            check("reg_alu_test", "alu.op", 32'(exp_op[k]), 32'(alu.op));
            check("reg_alu_test", "regs.dst", 32'(full_reg(rg[2:0], zz)), 32'(regs.dst));
            check("reg_alu_test", "regs.src", code, 32'(regs.src));
            check("reg_alu_test", "pointer", 32'(start + 8'd3), 32'(ptr));
        end
    endtask

    task automatic imm_alu_test();
        logic [31:0] rg;
        logic [31:0] n;
        logic [7:0]  start;
        draw(3, rg);
        draw(16, n);
        start = ptr;
        prog[start] = {4'b1100, 1'b1, rg[2:0]};              // byte ADD r,#
        prog[start + 8'd1] = 8'hc8;
        prog[start + 8'd2] = n[7:0];
        wait_strobe();
        check("imm_alu_test", "regs.we", 32'd1, 32'(regs.we));
        check("imm_alu_test", "regs.dst", 32'(full_reg(rg[2:0], 2'd0)), 32'(regs.dst));
        check("imm_alu_test", "alu.op", 32'(alu_add), 32'(alu.op));
        check("imm_alu_test", "alu.imm", {24'd0, n[7:0]}, alu.imm);
        check("imm_alu_test", "pointer", 32'(start + 8'd3), 32'(ptr));
        start = ptr;
        prog[start] = {4'b1101, 1'b1, rg[2:0]};              // word SBC r,#
        prog[start + 8'd1] = 8'hcb;
        prog[start + 8'd2] = n[7:0];
        prog[start + 8'd3] = n[15:8];
        wait_strobe();
        check("imm_alu_test", "regs.we", 32'd2, 32'(regs.we));
        check("imm_alu_test", "regs.dst", 32'(full_reg(rg[2:0], 2'd1)), 32'(regs.dst));
        check("imm_alu_test", "alu.op", 32'(alu_sbc), 32'(alu.op));
        check("imm_alu_test", "alu.imm", {16'd0, n[15:0]}, alu.imm);
        check("imm_alu_test", "pointer", 32'(start + 8'd4), 32'(ptr));
        start = ptr;
        prog[start] = {4'b1100, 1'b1, rg[2:0]};              // BIT #4,r
        prog[start + 8'd1] = 8'h33;
        prog[start + 8'd2] = n[7:0];
        wait_strobe();
        check("imm_alu_test", "flag_we", 32'd1, 32'(flag_we));
        check("imm_alu_test", "alu.op", 32'(alu_bit), 32'(alu.op));
        check("imm_alu_test", "alu.imm", {28'd0, n[3:0]}, alu.imm);
        check("imm_alu_test", "pointer", 32'(start + 8'd3), 32'(ptr));
        start = ptr;
        prog[start] = {4'b1101, 1'b1, rg[2:0]};              // BS1F
        prog[start + 8'd1] = 8'h0e;
        wait_strobe();
        check("imm_alu_test", "regs.we", 32'd2, 32'(regs.we));
        check("imm_alu_test", "regs.dst", 32'he0, 32'(regs.dst));
        check("imm_alu_test", "alu.op", 32'(alu_bs1f), 32'(alu.op));
        check("imm_alu_test", "pointer", 32'(start + 8'd2), 32'(ptr));
    endtask

    task automatic single_byte_test();
        logic [31:0] n;
        logic [7:0]  start;
        draw(8, n);
        prog[ptr] = 8'h12;                                  // CCF
        wait_strobe();
        check("single_byte_test", "flag_we", 32'd1, 32'(flag_we));
        check("single_byte_test", "alu.op", 32'(alu_ccf), 32'(alu.op));
        prog[ptr] = 8'h17;                                  // LDF #n
        prog[ptr + 8'd1] = n[7:0];
        wait_strobe();
        check("single_byte_test", "rfp_we", 32'd1, 32'(rfp_we));
        check("single_byte_test", "alu.imm", {24'd0, n[7:0]}, alu.imm);
        prog[ptr] = 8'h0c;                                  // INCF
        wait_strobe();
        check("single_byte_test", "inc_rfp", 32'd1, 32'(inc_rfp));
        prog[ptr] = 8'h0d;                                  // DECF
        wait_strobe();
        check("single_byte_test", "dec_rfp", 32'd1, 32'(dec_rfp));
        start = ptr;
        prog[start] = 8'h00;                                // NOP
        repeat (4) begin
            tick();
            check("single_byte_test", "strobes after NOP", 32'd0, 32'(any_strobe()));
        end
        check("single_byte_test", "pointer", 32'(start + 8'd1), 32'(ptr));
    endtask

    task automatic stall_test();
        logic [31:0] rg;
        logic [31:0] imm;
        logic [31:0] r;
        logic [7:0]  start;
        int          span;
        draw(3, rg);
        draw(32, imm);
        start = ptr;
        prog[start] = {4'b0100, 1'b0, rg[2:0]};              // long LD R,#
        for (int i = 0; i < 4; i++)
            prog[start + 8'(i) + 8'd1] = imm[8*i +: 8];
        span = 0;
        do begin
            if (span == 0) begin
                draw(2, r);
                span = int'(r[1:0]) + 1;
                op_ok = ~op_ok;
            end
            span--;
            tick();
            if (!op_ok)
                check("stall_test", "fetched while stalled", 32'd0, 32'(fetched));
            if (ptr != start && regs.we == 3'd0)
                check("stall_test", "alu.wait_imm during fill", 32'd1, 32'(alu.wait_imm));
        end while (regs.we == 3'd0);
        op_ok = 1'b1;
        check("stall_test", "regs.we", 32'd4, 32'(regs.we));
        check("stall_test", "alu.wait_imm", 32'd0, 32'(alu.wait_imm));
        check("stall_test", "alu.imm", imm, alu.imm);
        check("stall_test", "pointer", 32'(start + 8'd5), 32'(ptr));
    endtask

    initial begin
        for (int i = 0; i < 256; i++)
            prog[i] = 8'h01;                                // undecoded byte holds the fetch
        lfsr = 32'h78a1;
        cycles = 0;
        clk = 1'b0;
        rst = 1'b1;
        cen = 1'b1;
        op_ok = 1'b0;
        op = 32'h0101_0101;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        op_ok = 1'b1;
        ld_imm_test();
        jp_test();
        reg_alu_test();
        imm_alu_test();
        single_byte_test();
        stall_test();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
